/* cpu6Pkg.sv */
`default_nettype none

package cpu6Pkg;

   // data path and address width
   localparam int Xlen = 32;

   // fetch restarts here after an illegal instruction
   localparam logic [Xlen-1:0] TrapVector = 32'h100;

   // architectural register count including x0
   localparam int RegCount = 32;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      OpImm    = 7'b0010011,
      OpReg    = 7'b0110011,
      OpLui    = 7'b0110111,
      OpLoad   = 7'b0000011,
      OpStore  = 7'b0100011,
      OpBranch = 7'b1100011,
      OpJal    = 7'b1101111
   } opcodeT;

   // alu operations
   typedef enum logic [2:0] {
      AluAdd,
      AluSub,
      AluAnd,
      AluOr,
      AluXor,
      AluSlt,
      AluPassB
   } aluOpT;

   // immediate formats
   typedef enum logic [2:0] {
      ImmI,
      ImmS,
      ImmB,
      ImmU,
      ImmJ
   } immTypeT;

   // BrNone must stay at zero so that a cleared ctrl never redirects
   typedef enum logic [1:0] {
      BrNone,
      BrEq,
      BrNe,
      BrJal
   } branchTypeT;

   // decoder output carried into the execute stage
   typedef struct packed {
      logic       regWrite;
      logic       memToReg;
      logic       memWrite;
      logic       aluSrc;
      aluOpT      aluOp;
      immTypeT    immType;
      branchTypeT branchType;
   } ctrlT;

   // contents of the id/ex pipeline register
   typedef struct packed {
      logic            valid;
      ctrlT            ctrl;
      logic [Xlen-1:0] pc;
      logic [Xlen-1:0] instr;
   } idExT;

endpackage

`default_nettype wire

/* cpu6Fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu6Fetch (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      pcSrcE,
   input  logic [cpu6Pkg::Xlen-1:0] pcNextE,
   input  logic                      excpFlush,
   output logic [cpu6Pkg::Xlen-1:0] pcF
);

   logic [cpu6Pkg::Xlen-1:0] pcPlus4F;
   logic [cpu6Pkg::Xlen-1:0] pcNextF;

   // sequential fetch address
   assign pcPlus4F = pcF + cpu6Pkg::Xlen'(4);

   // a taken branch or jump in E wins over an exception
   // since the faulting word was then fetched on a wrong path
   always_comb begin
      if (pcSrcE) begin
         pcNextF = pcNextE;
      end else if (excpFlush) begin
         pcNextF = cpu6Pkg::TrapVector;
      end else begin
         pcNextF = pcPlus4F;
      end
   end

   // pc register, fetch starts at address zero
   always_ff @(posedge clk) begin
      if (rst) begin
         pcF <= '0;
      end else begin
         pcF <= pcNextF;
      end
   end

endmodule

`default_nettype wire

/* cpu6Decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu6Decoder (
   input  logic [cpu6Pkg::Xlen-1:0] instr,
   output cpu6Pkg::ctrlT             ctrl,
   output logic                      illegal
);

   cpu6Pkg::opcodeT opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;

   // instruction fields
   assign opcode = cpu6Pkg::opcodeT'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_comb begin
      // anything not matched below stays a zero ctrl and is flagged
      ctrl    = '0;
      illegal = 1'b0;
      case (opcode)
         cpu6Pkg::OpImm: begin
            // only addi
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = cpu6Pkg::AluAdd;
            ctrl.immType  = cpu6Pkg::ImmI;
            illegal       = (funct3 != 3'b000);
         end
         cpu6Pkg::OpReg: begin
            ctrl.regWrite = 1'b1;
            if (funct7 == 7'b0000000) begin
               case (funct3)
                  3'b000:  ctrl.aluOp = cpu6Pkg::AluAdd;
                  3'b010:  ctrl.aluOp = cpu6Pkg::AluSlt;
                  3'b100:  ctrl.aluOp = cpu6Pkg::AluXor;
                  3'b110:  ctrl.aluOp = cpu6Pkg::AluOr;
                  3'b111:  ctrl.aluOp = cpu6Pkg::AluAnd;
                  default: illegal = 1'b1;
               endcase
            end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
               // sub is the only alternate encoding kept
               ctrl.aluOp = cpu6Pkg::AluSub;
            end else begin
               illegal = 1'b1;
            end
         end
         cpu6Pkg::OpLui: begin
            // immediate goes straight through the alu
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = cpu6Pkg::AluPassB;
            ctrl.immType  = cpu6Pkg::ImmU;
         end
         cpu6Pkg::OpLoad: begin
            // word loads only
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = cpu6Pkg::AluAdd;
            ctrl.immType  = cpu6Pkg::ImmI;
            illegal       = (funct3 != 3'b010);
         end
         cpu6Pkg::OpStore: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.aluOp    = cpu6Pkg::AluAdd;
            ctrl.immType  = cpu6Pkg::ImmS;
            illegal       = (funct3 != 3'b010);
         end
         cpu6Pkg::OpBranch: begin
            // subtract and test for zero
            ctrl.aluOp   = cpu6Pkg::AluSub;
            ctrl.immType = cpu6Pkg::ImmB;
            case (funct3)
               3'b000:  ctrl.branchType = cpu6Pkg::BrEq;
               3'b001:  ctrl.branchType = cpu6Pkg::BrNe;
               default: illegal = 1'b1;
            endcase
         end
         cpu6Pkg::OpJal: begin
            ctrl.regWrite   = 1'b1;
            ctrl.immType    = cpu6Pkg::ImmJ;
            ctrl.branchType = cpu6Pkg::BrJal;
         end
         default: begin
            illegal = 1'b1;
         end
      endcase
      // partial matches above must not leak control bits
      if (illegal) begin
         ctrl = '0;
      end
   end

endmodule

`default_nettype wire

/* cpu6Excp.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu6Excp (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      illegal,
   input  logic                      pcSrcE,
   input  logic [cpu6Pkg::Xlen-1:0] pcF,
   output logic                      excpFlush,
   output logic [cpu6Pkg::Xlen-1:0] trapEpc
);

   // an illegal word behind a taken redirect is on the wrong path
   // and must not trap
   assign excpFlush = illegal & ~pcSrcE;

   // saved exception pc
   // holds the faulting fetch address until the next trap
   always_ff @(posedge clk) begin
      if (rst) begin
         trapEpc <= '0;
      end else if (excpFlush) begin
         trapEpc <= pcF;
      end
   end

endmodule

`default_nettype wire

/* cpu6IdEx.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu6IdEx (
   input  logic                      clk,
   input  logic                      rst,
   input  cpu6Pkg::ctrlT             ctrl,
   input  logic [cpu6Pkg::Xlen-1:0] pcF,
   input  logic [cpu6Pkg::Xlen-1:0] instr,
   input  logic                      pcSrcE,
   input  logic                      excpFlush,
   output cpu6Pkg::idExT             idEx
);

   logic flushE;

   // any redirect turns the word now in F into a bubble
   assign flushE = pcSrcE | excpFlush;

   // a bubble has valid low and a zero ctrl so it neither writes nor branches
   always_ff @(posedge clk) begin
      if (rst || flushE) begin
         idEx <= '0;
      end else begin
         idEx.valid <= 1'b1;
         idEx.ctrl  <= ctrl;
         idEx.pc    <= pcF;
         idEx.instr <= instr;
      end
   end

endmodule

`default_nettype wire

/* cpu6Datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu6Datapath (
   input  logic                      clk,
   input  logic                      rst,
   input  cpu6Pkg::idExT             idEx,
   output logic                      pcSrcE,
   output logic [cpu6Pkg::Xlen-1:0] pcNextE,
   output logic [cpu6Pkg::Xlen-1:0] dataAddr,
   output logic [cpu6Pkg::Xlen-1:0] writeData,
   output logic                      memWrite,
   input  logic [cpu6Pkg::Xlen-1:0] readData
);

   logic [cpu6Pkg::Xlen-1:0] regs [1:cpu6Pkg::RegCount-1];

   logic [31:0]              instrE;
   logic [4:0]               rs1Addr;
   logic [4:0]               rs2Addr;
   logic [4:0]               rdAddr;
   logic [cpu6Pkg::Xlen-1:0] rs1Data;
   logic [cpu6Pkg::Xlen-1:0] rs2Data;
   logic [cpu6Pkg::Xlen-1:0] immE;
   logic [cpu6Pkg::Xlen-1:0] srcB;
   logic [cpu6Pkg::Xlen-1:0] aluResult;
   logic                     zeroE;
   logic [cpu6Pkg::Xlen-1:0] pcPlus4E;
   logic [cpu6Pkg::Xlen-1:0] resultE;
   logic                     regWriteE;

   // register fields of the instruction in E
   assign instrE  = idEx.instr;
   assign rs1Addr = instrE[19:15];
   assign rs2Addr = instrE[24:20];
   assign rdAddr  = instrE[11:7];

   // x0 is not stored and always reads as zero
   assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
   assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

   // immediate generator, sign extended from bit 31
   always_comb begin
      case (idEx.ctrl.immType)
         cpu6Pkg::ImmS: immE = {{20{instrE[31]}}, instrE[31:25], instrE[11:7]};
         cpu6Pkg::ImmB: immE = {{19{instrE[31]}}, instrE[31], instrE[7],
                                instrE[30:25], instrE[11:8], 1'b0};
         cpu6Pkg::ImmU: immE = {instrE[31:12], 12'b0};
         cpu6Pkg::ImmJ: immE = {{11{instrE[31]}}, instrE[31], instrE[19:12],
                                instrE[20], instrE[30:21], 1'b0};
         default:       immE = {{20{instrE[31]}}, instrE[31:20]};
      endcase
   end

   // second alu operand
   assign srcB = idEx.ctrl.aluSrc ? immE : rs2Data;

   always_comb begin
      aluResult = '0;
      case (idEx.ctrl.aluOp)
         cpu6Pkg::AluAdd:   aluResult = rs1Data + srcB;
         cpu6Pkg::AluSub:   aluResult = rs1Data - srcB;
         cpu6Pkg::AluAnd:   aluResult = rs1Data & srcB;
         cpu6Pkg::AluOr:    aluResult = rs1Data | srcB;
         cpu6Pkg::AluXor:   aluResult = rs1Data ^ srcB;
         // signed compare, result in bit 0
         cpu6Pkg::AluSlt:   aluResult[0] = ($signed(rs1Data) < $signed(srcB));
         cpu6Pkg::AluPassB: aluResult = srcB;
         default:           aluResult = '0;
      endcase
   end

   // branches subtract, so equal operands give zero
   assign zeroE = (aluResult == '0);

   // branch and jump resolution
   always_comb begin
      case (idEx.ctrl.branchType)
         cpu6Pkg::BrEq:  pcSrcE = idEx.valid & zeroE;
         cpu6Pkg::BrNe:  pcSrcE = idEx.valid & ~zeroE;
         cpu6Pkg::BrJal: pcSrcE = idEx.valid;
         default:        pcSrcE = 1'b0;
      endcase
   end

   // target is pc relative for both branch and jal
   assign pcNextE  = idEx.pc + immE;
   assign pcPlus4E = idEx.pc + cpu6Pkg::Xlen'(4);

   // data memory request in the same cycle
   assign dataAddr  = aluResult;
   assign writeData = rs2Data;
   assign memWrite  = idEx.valid & idEx.ctrl.memWrite;

   // jal links pc+4, loads take the memory word
   always_comb begin
      if (idEx.ctrl.memToReg) begin
         resultE = readData;
      end else if (idEx.ctrl.branchType == cpu6Pkg::BrJal) begin
         resultE = pcPlus4E;
      end else begin
         resultE = aluResult;
      end
   end

   // bubbles and writes to x0 are dropped
   assign regWriteE = idEx.valid & idEx.ctrl.regWrite & (rdAddr != 5'd0);

   // writeback at the end of E
   // the next instruction reads the new value without forwarding
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < cpu6Pkg::RegCount; i++) begin
            regs[i] <= '0;
         end
      end else if (regWriteE) begin
         regs[rdAddr] <= resultE;
      end
   end

endmodule

`default_nettype wire

/* cpu6Core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu6Core (
   input  logic                      clk,
   input  logic                      rst,
   // instruction port, answers in the same cycle
   output logic [cpu6Pkg::Xlen-1:0] pcF,
   input  logic [cpu6Pkg::Xlen-1:0] instr,
   // data port
   output logic                      memWrite,
   output logic [cpu6Pkg::Xlen-1:0] dataAddr,
   output logic [cpu6Pkg::Xlen-1:0] writeData,
   input  logic [cpu6Pkg::Xlen-1:0] readData,
   // saved exception pc
   output logic [cpu6Pkg::Xlen-1:0] trapEpc
);

   cpu6Pkg::ctrlT            ctrl;
   cpu6Pkg::idExT            idEx;
   logic                     illegal;
   logic                     excpFlush;
   logic                     pcSrcE;
   logic [cpu6Pkg::Xlen-1:0] pcNextE;

   cpu6Fetch u_cpu6Fetch (
      .clk       (clk),
      .rst       (rst),
      .pcSrcE    (pcSrcE),
      .pcNextE   (pcNextE),
      .excpFlush (excpFlush),
      .pcF       (pcF)
   );

   cpu6Decoder u_cpu6Decoder (
      .instr   (instr),
      .ctrl    (ctrl),
      .illegal (illegal)
   );

   // trap decision sees the redirect from E
   cpu6Excp u_cpu6Excp (
      .clk       (clk),
      .rst       (rst),
      .illegal   (illegal),
      .pcSrcE    (pcSrcE),
      .pcF       (pcF),
      .excpFlush (excpFlush),
      .trapEpc   (trapEpc)
   );

   cpu6IdEx u_cpu6IdEx (
      .clk       (clk),
      .rst       (rst),
      .ctrl      (ctrl),
      .pcF       (pcF),
      .instr     (instr),
      .pcSrcE    (pcSrcE),
      .excpFlush (excpFlush),
      .idEx      (idEx)
   );

   cpu6Datapath u_cpu6Datapath (
      .clk       (clk),
      .rst       (rst),
      .idEx      (idEx),
      .pcSrcE    (pcSrcE),
      .pcNextE   (pcNextE),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .memWrite  (memWrite),
      .readData  (readData)
   );

endmodule

`default_nettype wire

/* cpu6CoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu6CoreTb;

   // run length and cycle limit
   localparam int StoreTarget   = 150;
   localparam int TimeoutCycles = 20000;

   logic        clk;
   logic        rst;
   logic [31:0] pcF;
   logic [31:0] instr;
   logic        memWrite;
   logic [31:0] dataAddr;
   logic [31:0] writeData;
   logic [31:0] readData;
   logic [31:0] trapEpc;

   // memories seen by the DUT
   logic [31:0] imem [0:127];
   logic [31:0] dmem [0:63];

   // model state, kept apart from the DUT memories
   logic [31:0] prog  [0:127];
   logic [31:0] mDmem [0:63];
   logic [31:0] mRegs [0:31];
   logic [31:0] mPc;
   logic [31:0] mEpc;

   int          errors;
   int          cycles;
   int          storeCount;
   logic        running;
   logic [31:0] expAddr;
   logic [31:0] expData;

   cpu6Core u_cpu6Core (
      .clk       (clk),
      .rst       (rst),
      .pcF       (pcF),
      .instr     (instr),
      .memWrite  (memWrite),
      .dataAddr  (dataAddr),
      .writeData (writeData),
      .readData  (readData),
      .trapEpc   (trapEpc)
   );

   // both memories answer in the same cycle
   assign instr    = imem[pcF[8:2]];
   assign readData = dmem[dataAddr[7:2]];

   always #50 clk = ~clk;

   task automatic compareValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      if (actual !== expected) begin
         errors++;
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic endRun();
      $display("errors: %0d, stores checked: %0d", errors, storeCount);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   // random program from the subset, branches and jumps always forward
   task automatic fillProgram();
      int          i;
      int          kind;
      logic [31:0] r;
      logic [31:0] r2;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] off;
      logic [11:0] sOff;
      logic [3:0]  words;
      logic [12:0] bOff;
      logic [20:0] jOff;
      logic [31:0] w;
      logic        pair;
      i = 0;
      while (i < 128) begin
         kind  = $urandom_range(0, 39);
         r     = $urandom;
         r2    = $urandom;
         rd    = {2'b00, r[2:0]};
         rs1   = {2'b00, r[5:3]};
         rs2   = {2'b00, r[8:6]};
         off   = {4'b0000, r2[5:0], 2'b00};
         sOff  = {4'b0000, r2[15:10], 2'b00};
         words = {1'b0, r2[8:6]} + 4'd1;
         bOff  = {7'b0, words, 2'b00};
         jOff  = {15'b0, words, 2'b00};
         pair  = 1'b0;
         // illegal words stay below the trap vector so a trap never loops back
         if (i < 64 && $urandom_range(0, 19) == 0) begin
            w = {r2[31:7], 7'h7f};
         end else if (kind < 10) begin
            w = {r2[31:20], rs1, 3'b000, rd, 7'h13};
         end else if (kind < 18) begin
            case ($urandom_range(0, 5))
               0:       w = {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
               1:       w = {7'h00, rs2, rs1, 3'b010, rd, 7'h33};
               2:       w = {7'h00, rs2, rs1, 3'b100, rd, 7'h33};
               3:       w = {7'h00, rs2, rs1, 3'b110, rd, 7'h33};
               4:       w = {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
               default: w = {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
            endcase
         end else if (kind < 21) begin
            w = {r2[31:12], rd, 7'h37};
         end else if (kind < 24) begin
            // load, then store of its destination
            w    = {off, 5'd0, 3'b010, rd, 7'h03};
            pair = (i < 127);
         end else if (kind < 31) begin
            w = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'h23};
         end else if (kind < 37) begin
            // compare among x0..x3 so both outcomes happen
            w = {bOff[12], bOff[10:5], {3'b000, r[7:6]}, {3'b000, r[4:3]},
                 (r2[9] ? 3'b001 : 3'b000), bOff[4:1], bOff[11], 7'h63};
         end else begin
            w = {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, 7'h6f};
         end
         imem[i] = w;
         prog[i] = w;
         if (pair) begin
            w           = {sOff[11:5], rd, 5'd0, 3'b010, sOff[4:0], 7'h23};
            imem[i + 1] = w;
            prog[i + 1] = w;
            i           = i + 2;
         end else begin
            i = i + 1;
         end
      end
   endtask

   // one instruction of the instruction-set model
   task automatic stepIsa(output logic stored, output logic [31:0] sAddr,
                          output logic [31:0] sData);
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] immI;
      logic [31:0] immS;
      logic [31:0] immB;
      logic [31:0] immJ;
      logic [31:0] ea;
      logic [31:0] res;
      logic [31:0] nextPc;
      logic        wr;
      logic        legal;
      w      = prog[mPc[8:2]];
      a      = mRegs[w[19:15]];
      b      = mRegs[w[24:20]];
      immI   = {{20{w[31]}}, w[31:20]};
      immS   = {{20{w[31]}}, w[31:25], w[11:7]};
      immB   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      immJ   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      stored = 1'b0;
      sAddr  = '0;
      sData  = '0;
      res    = '0;
      wr     = 1'b0;
      legal  = 1'b1;
      nextPc = mPc + 32'd4;
      case (w[6:0])
         7'h13: begin
            legal = (w[14:12] == 3'b000);
            res   = a + immI;
            wr    = 1'b1;
         end
         7'h33: begin
            wr = 1'b1;
            if (w[31:25] == 7'h20 && w[14:12] == 3'b000) begin
               res = a - b;
            end else if (w[31:25] != 7'h00) begin
               legal = 1'b0;
            end else begin
               case (w[14:12])
                  3'b000:  res = a + b;
                  3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  3'b111:  res = a & b;
                  default: legal = 1'b0;
               endcase
            end
         end
         7'h37: begin
            res = {w[31:12], 12'b0};
            wr  = 1'b1;
         end
         7'h03: begin
            legal = (w[14:12] == 3'b010);
            ea    = a + immI;
            res   = mDmem[ea[7:2]];
            wr    = 1'b1;
         end
         7'h23: begin
            legal = (w[14:12] == 3'b010);
            if (legal) begin
               stored             = 1'b1;
               sAddr              = a + immS;
               sData              = b;
               mDmem[sAddr[7:2]]  = b;
            end
         end
         7'h63: begin
            if (w[14:12] == 3'b000) begin
               if (a == b) nextPc = mPc + immB;
            end else if (w[14:12] == 3'b001) begin
               if (a != b) nextPc = mPc + immB;
            end else begin
               legal = 1'b0;
            end
         end
         7'h6f: begin
            res    = mPc + 32'd4;
            wr     = 1'b1;
            nextPc = mPc + immJ;
         end
         default: legal = 1'b0;
      endcase
      if (!legal) begin
         // trap: remember the pc and restart at the vector
         mEpc = mPc;
         mPc  = cpu6Pkg::TrapVector;
      end else begin
         if (wr && w[11:7] != 5'd0) mRegs[w[11:7]] = res;
         mPc = nextPc;
      end
   endtask

   // run the model up to its next store
   task automatic expectStore(output logic [31:0] addr, output logic [31:0] data);
      logic stored;
      int   steps;
      stored = 1'b0;
      steps  = 0;
      while (!stored && steps < 10000) begin
         stepIsa(stored, addr, data);
         steps++;
      end
      if (!stored) begin
         errors++;
         $display("model ran %0d instructions without reaching a store", steps);
      end
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      errors     = 0;
      cycles     = 0;
      storeCount = 0;
      running    = 1'b0;
      mPc        = '0;
      mEpc       = '0;
      void'($urandom(32'h7739));
      for (int i = 0; i < 32; i++) begin
         mRegs[i] = '0;
      end
      // same random contents in DUT memory and model copy
      for (int i = 0; i < 64; i++) begin
         dmem[i]  = $urandom;
         mDmem[i] = dmem[i];
      end
      fillProgram();
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   end

   // data memory write and cycle limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (memWrite === 1'b1) begin
         dmem[dataAddr[7:2]] <= writeData;
      end
      if (cycles >= TimeoutCycles) begin
         errors++;
         $display("timeout after %0d cycles with %0d of %0d stores seen",
                  cycles, storeCount, StoreTarget);
         endRun();
      end
   end

   // outputs are settled at the falling edge
   always @(negedge clk) begin
      if (cycles > 0) begin
         if (rst) begin
            compareValue("resetMemWrite", 32'd0, {31'b0, memWrite});
            compareValue("resetPc", 32'd0, pcF);
         end else begin
            if (!running) begin
               // first fetch after reset
               compareValue("firstPc", 32'd0, pcF);
               compareValue("firstMemWrite", 32'd0, {31'b0, memWrite});
               running = 1'b1;
            end
            if (memWrite) begin
               expectStore(expAddr, expData);
               compareValue("storeAddr", expAddr, dataAddr);
               compareValue("storeData", expData, writeData);
               compareValue("trapEpc", mEpc, trapEpc);
               storeCount++;
               if (storeCount == StoreTarget) endRun();
            end
         end
      end
   end

endmodule

`default_nettype wire

/* cpu6Core.f */
cpu6Pkg.sv
cpu6Fetch.sv
cpu6Decoder.sv
cpu6Excp.sv
cpu6IdEx.sv
cpu6Datapath.sv
cpu6Core.sv
cpu6CoreTb.sv
